// ==== src.f ====
common/muldiv_pkg.sv
common/hilo_pkg.sv
multiplier/multiplier.sv
divider/divider.sv
hdl/muldiv_issue.sv
hdl/hilo_writeback.sv
hdl/muldiv_unit.sv
bench/tb_muldiv.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_muldiv
RTL_TOP ?= muldiv_unit
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_muldiv.sv ====
`timescale 1ns/100ps

module tb_muldiv;

	localparam int N = muldiv_pkg::DATA_BITS;
	localparam int NUM_REQ = 300;
	localparam int MAX_CYCLES = NUM_REQ * 40 * 2;  // twice the gap plus latency of each request
	localparam int MIN_LAT = N + 2;                // issue to wb_valid without a conflict

	logic clk;
	logic rst;
	logic issue;
	muldiv_pkg::md_req_t req;
	logic [1:0] busy;
	logic reject;
	logic wb_valid;
	hilo_pkg::wb_t wb;
	logic [N-1:0] hi;
	logic [N-1:0] lo;

	hilo_pkg::eng_result_t res_q[2][$];  // expected results per engine (0 mul, 1 div)
	int time_q[2][$];                    // issue cycle of each result
	logic [1:0] model_busy;
	logic [N-1:0] exp_hi;
	logic [N-1:0] exp_lo;
	logic [31:0] rng;
	int cycle = 0;
	int errors = 0;
	int accepted = 0;
	int rejected = 0;
	int writes = 0;

	muldiv_unit i_dut (
		.clk      (clk),
		.rst      (rst),
		.issue    (issue),
		.req      (req),
		.busy     (busy),
		.reject   (reject),
		.wb_valid (wb_valid),
		.wb       (wb),
		.hi       (hi),
		.lo       (lo)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle == MAX_CYCLES) begin
			$display("run stopped at the cycle limit of %0d with %0d errors",
				MAX_CYCLES, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);  // xorshift32
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic muldiv_pkg::md_req_t random_request();
		muldiv_pkg::md_req_t r;
		logic [31:0] pick;
		int kind;
		pick = next_random();
		kind = int'(pick[15:8]) % 10;
		r.op = muldiv_pkg::md_op_e'(pick[1:0]);
		r.a = N'(next_random());
		r.b = N'(next_random());
		if (kind == 0)
			r.b = '0;  // zero divisor
		else if (kind == 1) begin
			r.a = {1'b1, {(N-1){1'b0}}};  // most negative by minus one
			r.b = '1;
		end
		return r;
	endfunction

	// works on magnitudes and applies the signs after
	function automatic hilo_pkg::eng_result_t expected_result(input muldiv_pkg::md_req_t r);
		logic is_signed;
		logic [N-1:0] ma;
		logic [N-1:0] mb;
		logic [N-1:0] q;
		logic [N-1:0] rm;
		logic [2*N-1:0] p;
		hilo_pkg::eng_result_t res;
		is_signed = (r.op == muldiv_pkg::OP_MULT) || (r.op == muldiv_pkg::OP_DIV);
		ma = (is_signed && r.a[N-1]) ? -r.a : r.a;
		mb = (is_signed && r.b[N-1]) ? -r.b : r.b;
		if (r.op == muldiv_pkg::OP_MULT || r.op == muldiv_pkg::OP_MULTU) begin
			p = {{N{1'b0}}, ma} * {{N{1'b0}}, mb};
			if (is_signed && (r.a[N-1] ^ r.b[N-1]))
				p = -p;
			res = hilo_pkg::eng_result_t'(p);
		end else begin
			if (mb == '0) begin
				q = '1;
				rm = ma;
			end else begin
				q = ma / mb;
				rm = ma % mb;
			end
			if (is_signed && (r.a[N-1] ^ r.b[N-1]))
				q = -q;
			if (is_signed && r.a[N-1])
				rm = -rm;  // remainder follows the dividend
			res.hi = rm;
			res.lo = q;
		end
		return res;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic log_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	// one clock of checks on registered outputs, then new inputs and the reject check
	task automatic run_cycle(input logic do_issue, input muldiv_pkg::md_req_t r);
		int src;
		int lat;
		logic to_div;
		logic exp_reject;
		logic [1:0] retiring;
		hilo_pkg::eng_result_t exp_res;
		@(negedge clk);
		retiring = 2'b00;
		if (busy !== model_busy) report_mismatch("busy", 64'(busy), 64'(model_busy));
		if (hi !== exp_hi) report_mismatch("hi", 64'(hi), 64'(exp_hi));
		if (lo !== exp_lo) report_mismatch("lo", 64'(lo), 64'(exp_lo));
		if (wb_valid === 1'b1) begin
			writes++;
			src = (wb.src == hilo_pkg::SRC_DIV) ? 1 : 0;
			if (res_q[src].size() == 0) begin
				log_error($sformatf("write from engine %0d with no result outstanding",
					src));
			end else begin
				exp_res = res_q[src].pop_front();
				lat = cycle - time_q[src].pop_front();
				if (wb.hi !== exp_res.hi) report_mismatch("wb.hi", 64'(wb.hi), 64'(exp_res.hi));
				if (wb.lo !== exp_res.lo) report_mismatch("wb.lo", 64'(wb.lo), 64'(exp_res.lo));
				if (lat < MIN_LAT || lat > MIN_LAT + 1)
					log_error($sformatf("write came %0d cycles after its issue", lat));
				exp_hi = exp_res.hi;  // HI/LO follow on the next edge
				exp_lo = exp_res.lo;
				retiring[src] = 1'b1;
			end
		end
		issue = do_issue;
		req = r;
		#1;
		to_div = (r.op == muldiv_pkg::OP_DIV) || (r.op == muldiv_pkg::OP_DIVU);
		exp_reject = do_issue && model_busy[to_div];
		if (reject !== exp_reject) report_mismatch("reject", 64'(reject), 64'(exp_reject));
		if (do_issue && exp_reject) begin
			rejected++;
		end else if (do_issue) begin
			accepted++;
			res_q[to_div].push_back(expected_result(r));
			time_q[to_div].push_back(cycle);
			model_busy[to_div] = 1'b1;
		end
		model_busy = model_busy & ~retiring;  // busy drops on the retire edge
	endtask

	initial begin
		muldiv_pkg::md_req_t r;
		logic [31:0] pick;
		rst = 1'b1;
		issue = 1'b0;
		req = '0;
		rng = 32'd936;
		model_busy = 2'b00;
		exp_hi = '0;
		exp_lo = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (wb_valid !== 1'b0) report_mismatch("wb_valid", 64'(wb_valid), 64'd0);
		if (reject !== 1'b0) report_mismatch("reject", 64'(reject), 64'd0);
		if (busy !== 2'b00) report_mismatch("busy", 64'(busy), 64'd0);
		if (hi !== '0) report_mismatch("hi", 64'(hi), 64'd0);
		if (lo !== '0) report_mismatch("lo", 64'(lo), 64'd0);
		rst = 1'b0;
		// back to back on both engines
		r.op = muldiv_pkg::OP_MULT;
		r.a = {1'b1, {(N-1){1'b0}}};
		r.b = '1;
		run_cycle(1'b1, r);
		r.op = muldiv_pkg::OP_DIV;
		run_cycle(1'b1, r);
		for (int n = 0; n < NUM_REQ; n++) begin
			pick = next_random();
			repeat (int'(pick[4:0])) run_cycle(1'b0, '0);
			run_cycle(1'b1, random_request());
		end
		repeat (MIN_LAT + 4) run_cycle(1'b0, '0);  // longest latency plus a few idle cycles
		if (res_q[0].size() != 0 || res_q[1].size() != 0)
			log_error("expected results were never written back");
		$display("requests %0d, accepted %0d, rejected %0d, writes %0d, errors %0d",
			NUM_REQ + 2, accepted, rejected, writes, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== hdl/muldiv_unit.sv ====
`timescale 1ns/100ps

module muldiv_unit (
	input  logic clk,
	input  logic rst,
	input  logic issue,
	input  muldiv_pkg::md_req_t req,
	output logic [1:0] busy,                          // bit 0 mul, bit 1 div
	output logic reject,
	output logic wb_valid,
	output hilo_pkg::wb_t wb,
	output logic [muldiv_pkg::DATA_BITS-1:0] hi,
	output logic [muldiv_pkg::DATA_BITS-1:0] lo
);

	logic mul_start;
	logic div_start;
	logic sign;
	logic [muldiv_pkg::DATA_BITS-1:0] op_a;
	logic [muldiv_pkg::DATA_BITS-1:0] op_b;
	logic mul_done;
	logic div_done;
	hilo_pkg::eng_result_t mul_result;
	hilo_pkg::eng_result_t div_result;
	logic retire_mul;
	logic retire_div;

	muldiv_issue i_issue (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.req        (req),
		.retire_mul (retire_mul),
		.retire_div (retire_div),
		.mul_start  (mul_start),
		.div_start  (div_start),
		.sign       (sign),
		.op_a       (op_a),
		.op_b       (op_b),
		.busy       (busy),
		.reject     (reject)
	);

	// operands are shared, only the started engine loads them
	multiplier i_mul (
		.clk          (clk),
		.rst          (rst),
		.start        (mul_start),
		.sign         (sign),
		.multiplicand (op_a),
		.multiplier   (op_b),
		.done         (mul_done),
		.result       (mul_result)
	);

	divider i_div (
		.clk      (clk),
		.rst      (rst),
		.start    (div_start),
		.sign     (sign),
		.dividend (op_a),
		.divisor  (op_b),
		.done     (div_done),
		.result   (div_result)
	);

	hilo_writeback i_wb (
		.clk        (clk),
		.rst        (rst),
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.div_done   (div_done),
		.div_result (div_result),
		.wb_valid   (wb_valid),
		.wb         (wb),
		.hi         (hi),
		.lo         (lo),
		.retire_mul (retire_mul),
		.retire_div (retire_div)
	);

endmodule

// ==== hdl/hilo_writeback.sv ====
`timescale 1ns/100ps

module hilo_writeback (
	input  logic clk,
	input  logic rst,
	input  logic mul_done,
	input  hilo_pkg::eng_result_t mul_result,
	input  logic div_done,
	input  hilo_pkg::eng_result_t div_result,
	output logic wb_valid,                            // one write per cycle
	output hilo_pkg::wb_t wb,                         // the granted write
	output logic [muldiv_pkg::DATA_BITS-1:0] hi,
	output logic [muldiv_pkg::DATA_BITS-1:0] lo,
	output logic retire_mul,
	output logic retire_div
);

	hilo_pkg::eng_result_t mul_slot;
	hilo_pkg::eng_result_t div_slot;
	logic mul_pend;
	logic div_pend;
	hilo_pkg::wb_src_e last_src;                      // last granted source
	logic grant_mul;
	logic grant_div;

	// round robin only matters when both slots wait
	assign grant_mul = mul_pend && (!div_pend || last_src == hilo_pkg::SRC_DIV);
	assign grant_div = div_pend && !grant_mul;

	assign wb_valid = grant_mul || grant_div;
	assign retire_mul = grant_mul;
	assign retire_div = grant_div;

	always_comb begin
		wb.src = grant_div ? hilo_pkg::SRC_DIV : hilo_pkg::SRC_MUL;
		{wb.hi, wb.lo} = grant_div ? div_slot : mul_slot;
	end

	always_ff @(posedge clk) begin
		if (mul_done)
			mul_slot <= mul_result;
		if (div_done)
			div_slot <= div_result;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mul_pend <= 1'b0;
			div_pend <= 1'b0;
			last_src <= hilo_pkg::SRC_DIV;  // mul wins the first tie
			hi <= '0;
			lo <= '0;
		end else begin
			if (mul_done)
				mul_pend <= 1'b1;
			else if (grant_mul)
				mul_pend <= 1'b0;
			if (div_done)
				div_pend <= 1'b1;
			else if (grant_div)
				div_pend <= 1'b0;
			if (wb_valid) begin
				last_src <= wb.src;
				hi <= wb.hi;
				lo <= wb.lo;
			end
		end
	end

	// HI/LO may only change after a cycle with a pending result
	a_write_from_slot: assert property (@(posedge clk) disable iff (rst)
		(hi != $past(hi) || lo != $past(lo)) |-> $past(mul_pend || div_pend))
		else $error("HI/LO written with both slots empty");

endmodule

// ==== hdl/muldiv_issue.sv ====
`timescale 1ns/100ps

module muldiv_issue (
	input  logic clk,
	input  logic rst,
	input  logic issue,                               // one-cycle request strobe
	input  muldiv_pkg::md_req_t req,
	input  logic retire_mul,                          // from writeback grant
	input  logic retire_div,
	output logic mul_start,
	output logic div_start,
	output logic sign,                                // shared by both engines
	output logic [muldiv_pkg::DATA_BITS-1:0] op_a,
	output logic [muldiv_pkg::DATA_BITS-1:0] op_b,
	output logic [1:0] busy,                          // bit 0 mul, bit 1 div
	output logic reject                               // request dropped
);

	logic to_div;

	assign to_div = (req.op == muldiv_pkg::OP_DIV) || (req.op == muldiv_pkg::OP_DIVU);
	assign sign = (req.op == muldiv_pkg::OP_MULT) || (req.op == muldiv_pkg::OP_DIV);
	assign op_a = req.a;
	assign op_b = req.b;

	assign mul_start = issue && !to_div && !busy[0];
	assign div_start = issue && to_div && !busy[1];
	assign reject = issue && (to_div ? busy[1] : busy[0]);

	// busy runs from the start edge to the retire edge
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 2'b00;
		end else begin
			if (mul_start)
				busy[0] <= 1'b1;
			else if (retire_mul)
				busy[0] <= 1'b0;
			if (div_start)
				busy[1] <= 1'b1;
			else if (retire_div)
				busy[1] <= 1'b0;
		end
	end

	// an engine still busy and not retiring this cycle must not be restarted next cycle
	a_mul_no_restart: assert property (@(posedge clk) disable iff (rst)
		busy[0] && !retire_mul |=> !mul_start)
		else $error("multiplier started while busy");
	a_div_no_restart: assert property (@(posedge clk) disable iff (rst)
		busy[1] && !retire_div |=> !div_start)
		else $error("divider started while busy");

endmodule

// ==== divider/divider.sv ====
`timescale 1ns/100ps

module divider (
	input  logic clk,
	input  logic rst,
	input  logic start,                                  // load operands, begin
	input  logic sign,                                   // signed divide
	input  logic [muldiv_pkg::DATA_BITS-1:0] dividend,
	input  logic [muldiv_pkg::DATA_BITS-1:0] divisor,
	output logic done,                                   // one-cycle pulse
	output hilo_pkg::eng_result_t result                 // hi remainder, lo quotient
);

	localparam int N = muldiv_pkg::DATA_BITS;
	localparam int CNT_BITS = $clog2(N);

	muldiv_pkg::eng_state_e state;
	muldiv_pkg::eng_state_e next_state;
	logic load;
	logic step;
	logic [CNT_BITS-1:0] count;
	logic [N-1:0] dsor;      // divisor magnitude
	logic [N-1:0] rem;       // partial remainder
	logic [N-1:0] quot;      // dividend shifts out, quotient shifts in
	logic neg_quot;
	logic neg_rem;
	logic [N:0] partial;
	logic [N-1:0] diff;
	logic fits;

	always_comb begin
		load = 1'b0;
		step = 1'b0;
		next_state = muldiv_pkg::S_IDLE;
		case (state)
			muldiv_pkg::S_IDLE: begin
				if (start) begin
					load = 1'b1;
					next_state = muldiv_pkg::S_CALC;
				end
			end
			muldiv_pkg::S_CALC: begin
				step = 1'b1;
				if (count == CNT_BITS'(N-1))
					next_state = muldiv_pkg::S_DONE;
				else
					next_state = muldiv_pkg::S_CALC;
			end
			default: next_state = muldiv_pkg::S_IDLE;  // S_DONE back to idle
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= muldiv_pkg::S_IDLE;
			count <= '0;
		end else begin
			state <= next_state;
			if (load)
				count <= '0;
			else if (step)
				count <= count + 1'b1;
		end
	end

	// restore step: bring down next dividend bit, subtract if it fits
	assign partial = {rem, quot[N-1]};
	assign fits = partial >= {1'b0, dsor};
	assign diff = partial[N-1:0] - dsor;  // only kept when it fits

	always_ff @(posedge clk) begin
		if (load) begin
			dsor <= (sign && divisor[N-1]) ? -divisor : divisor;
			quot <= (sign && dividend[N-1]) ? -dividend : dividend;
			rem <= '0;
			neg_quot <= sign && (dividend[N-1] ^ divisor[N-1]);
			neg_rem <= sign && dividend[N-1];  // remainder takes dividend sign
		end else if (step) begin
			rem <= fits ? diff : partial[N-1:0];
			quot <= {quot[N-2:0], fits};
		end
	end

	// zero divisor always fits, so quotient ends all ones
	assign result.lo = neg_quot ? -quot : quot;
	assign result.hi = neg_rem ? -rem : rem;
	assign done = (state == muldiv_pkg::S_DONE);

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("divider done held longer than one cycle");

endmodule

// ==== multiplier/multiplier.sv ====
`timescale 1ns/100ps

module multiplier (
	input  logic clk,
	input  logic rst,
	input  logic start,                                  // load operands, begin
	input  logic sign,                                   // signed multiply
	input  logic [muldiv_pkg::DATA_BITS-1:0] multiplicand,
	input  logic [muldiv_pkg::DATA_BITS-1:0] multiplier,
	output logic done,                                   // one-cycle pulse
	output hilo_pkg::eng_result_t result                 // 64-bit product
);

	localparam int N = muldiv_pkg::DATA_BITS;
	localparam int CNT_BITS = $clog2(N);

	muldiv_pkg::eng_state_e state;
	muldiv_pkg::eng_state_e next_state;
	logic load;
	logic step;
	logic [CNT_BITS-1:0] count;
	logic [N-1:0] mcand;     // multiplicand magnitude
	logic [2*N-1:0] prod;    // upper half accumulates, lower half holds multiplier
	logic neg_prod;
	logic [N:0] sum;
	logic [2*N-1:0] product;

	always_comb begin
		load = 1'b0;
		step = 1'b0;
		next_state = muldiv_pkg::S_IDLE;
		case (state)
			muldiv_pkg::S_IDLE: begin
				if (start) begin
					load = 1'b1;
					next_state = muldiv_pkg::S_CALC;
				end
			end
			muldiv_pkg::S_CALC: begin
				step = 1'b1;
				if (count == CNT_BITS'(N-1))
					next_state = muldiv_pkg::S_DONE;
				else
					next_state = muldiv_pkg::S_CALC;
			end
			default: next_state = muldiv_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= muldiv_pkg::S_IDLE;
			count <= '0;
		end else begin
			state <= next_state;
			if (load)
				count <= '0;
			else if (step)
				count <= count + 1'b1;
		end
	end

	// add when the current multiplier bit is set, carry goes into the shift
	assign sum = {1'b0, prod[2*N-1:N]} + (prod[0] ? {1'b0, mcand} : {(N+1){1'b0}});

	always_ff @(posedge clk) begin
		if (load) begin
			mcand <= (sign && multiplicand[N-1]) ? -multiplicand : multiplicand;
			prod <= {{N{1'b0}}, (sign && multiplier[N-1]) ? -multiplier : multiplier};
			neg_prod <= sign && (multiplicand[N-1] ^ multiplier[N-1]);
		end else if (step) begin
			prod <= {sum, prod[N-1:1]};
		end
	end

	assign product = neg_prod ? -prod : prod;
	assign result = hilo_pkg::eng_result_t'(product);
	assign done = (state == muldiv_pkg::S_DONE);

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("multiplier done held longer than one cycle");

endmodule

// ==== common/hilo_pkg.sv ====
package hilo_pkg;

	typedef enum logic {
		SRC_MUL,  // multiplier engine
		SRC_DIV   // divider engine
	} wb_src_e;

	// multiply gives the upper and lower product words,
	// divide gives the remainder in hi and the quotient in lo
	typedef struct packed {
		logic [muldiv_pkg::DATA_BITS-1:0] hi;
		logic [muldiv_pkg::DATA_BITS-1:0] lo;
	} eng_result_t;

	typedef struct packed {
		wb_src_e src;
		logic [muldiv_pkg::DATA_BITS-1:0] hi;
		logic [muldiv_pkg::DATA_BITS-1:0] lo;
	} wb_t;

endpackage

// ==== common/muldiv_pkg.sv ====
package muldiv_pkg;

	localparam int DATA_BITS = 32;  // operand width

	// opcode order matches the MIPS funct low bits
	typedef enum logic [1:0] {
		OP_MULT,   // signed multiply
		OP_MULTU,  // unsigned multiply
		OP_DIV,    // signed divide
		OP_DIVU    // unsigned divide
	} md_op_e;

	typedef enum logic [1:0] {
		S_IDLE,  // waiting for start
		S_CALC,  // one step per cycle
		S_DONE   // result valid, done high
	} eng_state_e;

	typedef struct packed {
		md_op_e op;
		logic [DATA_BITS-1:0] a;  // multiplicand or dividend
		logic [DATA_BITS-1:0] b;  // multiplier or divisor
	} md_req_t;

endpackage
